//--- bench/frontEndBench.sv
`timescale 1ns/1ns
`default_nettype none

module frontEndBench import mipsIsaPkg::*, renamePkg::*; ();

	localparam int programWords = 256;
	// Reset, 40 instructions and a few redirects need well under 200 cycles
	localparam int cycleLimit = 2000;
	localparam int renamedTarget = 40;
	localparam int stallTarget = 10;

	logic CLK;
	logic rstN;
	wordT instrAddr;
	wordT instrData;
	renamedT renamed;
	logic renamedValid;
	logic renameStall;

	wordT programMem [programWords];
	logic runDone = 1'b0;

	// Reference model state
	physRegT modelMap [numArchRegs];
	wordT expectedPc;
	int allocCount;
	int renamedCount;
	int stallCycles;
	int sinceRelease;
	int cycleCount;

	mipsFrontEnd mipsFrontEnd_i (
		.CLK(CLK),
		.rstN(rstN),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.renamed(renamed),
		.renamedValid(renamedValid),
		.renameStall(renameStall)
	);

	// Instruction memory answers in the same cycle
	assign instrData = programMem[instrAddr[9:2]];

	// --------------------------------------------------
	// Program generation
	// --------------------------------------------------
	function automatic archRegT randomReg();
		return archRegT'($urandom_range(31, 0));
	endfunction

	function automatic wordT immWord(opcodeT op, archRegT rt);
		instrT w;
		w = '0;
		w.i.opcode = op;
		w.i.rs = randomReg();
		w.i.rt = rt;
		w.i.imm = 16'($urandom());
		return w;
	endfunction

	// Target slot is a word index, so the address is slot * 4
	function automatic wordT jumpWord(opcodeT op, int targetSlot);
		instrT w;
		w = '0;
		w.j.opcode = op;
		w.j.index = 26'(targetSlot);
		return w;
	endfunction

	function automatic wordT writerWord();
		instrT w;
		w = '0;
		case ($urandom_range(2, 0))
			0: begin
				w.r.opcode = opRType;
				w.r.rs = randomReg();
				w.r.rt = randomReg();
				w.r.rd = randomReg();
				w.r.funct = 6'h20;
			end
			1: w = immWord(opAddi, randomReg());
			default: w = immWord(opLw, randomReg());
		endcase
		return w;
	endfunction

	// Slots 9 and 19 always jump forward
	function automatic wordT nonWriter(int slot);
		int target;
		int pick;
		target = slot + int'($urandom_range(6, 2));
		if (slot == 9) begin
			pick = 3;
		end else if (slot == 19) begin
			pick = 4;
		end else begin
			pick = int'($urandom_range(4, 0));
		end
		if (pick >= 3 && target >= programWords) begin
			pick = 1;
		end
		case (pick)
			0: return immWord(opSw, randomReg());
			1: return immWord(opBeq, randomReg());
			2: return immWord(opBne, randomReg());
			3: return jumpWord(opJ, target);
			default: return jumpWord(opJal, target);
		endcase
	endfunction

	// Mostly writers so the free list runs dry within the run
	task automatic fillProgram();
		for (int i = 0; i < programWords; i++) begin
			if (i == 2) begin
				programMem[i] = immWord(opAddi, 5'd0);
			end else if (i % 10 == 9) begin
				programMem[i] = nonWriter(i);
			end else begin
				programMem[i] = writerWord();
			end
		end
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	// Destination by opcode or 0 when nothing is written
	function automatic archRegT destOf(instrT w);
		case (w.r.opcode)
			opRType: return w.r.rd;
			opJal: return linkReg;
			opJ, opBeq, opBne, opSw: return '0;
			default: return w.i.rt;
		endcase
	endfunction

	function automatic wordT nextPcOf(wordT pc, instrT w);
		wordT seqPc;
		seqPc = pc + 32'd4;
		if (w.j.opcode == opJ || w.j.opcode == opJal) begin
			// Stays in the 256 MB region of the next sequential address
			return (seqPc & 32'hF000_0000) | (wordT'(w.j.index) << 2);
		end
		return seqPc;
	endfunction

	task automatic failCheck(string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkRenamed();
		archRegT dest;
		dest = destOf(renamed.instr);
		pcOrder: assert (renamed.pc == expectedPc) else
			failCheck($sformatf("pc %h, expected %h", renamed.pc, expectedPc));
		instrMatch: assert (renamed.instr == programMem[renamed.pc[9:2]]) else
			failCheck($sformatf("instr %h at pc %h", renamed.instr, renamed.pc));
		srcAMap: assert (renamed.physA == modelMap[renamed.instr.r.rs]) else
			failCheck($sformatf("physA %0d, expected %0d", renamed.physA,
				modelMap[renamed.instr.r.rs]));
		srcBMap: assert (renamed.physB == modelMap[renamed.instr.r.rt]) else
			failCheck($sformatf("physB %0d, expected %0d", renamed.physB,
				modelMap[renamed.instr.r.rt]));
		if (dest != '0) begin
			freeLeft: assert (allocCount < numPhysRegs - numArchRegs) else
				failCheck("writer renamed with an empty free list");
			destAlloc: assert (renamed.regWrite
				&& renamed.physDest == physRegT'(numArchRegs + allocCount)) else
				failCheck($sformatf("physDest %0d, expected %0d", renamed.physDest,
					numArchRegs + allocCount));
			modelMap[dest] = physRegT'(numArchRegs + allocCount);
			allocCount++;
		end else begin
			noAlloc: assert (!renamed.regWrite && renamed.physDest == '0) else
				failCheck($sformatf("non-writer got physDest %0d", renamed.physDest));
		end
		expectedPc = nextPcOf(renamed.pc, renamed.instr);
		renamedCount++;
	endtask

	// Outputs are sampled before the edge updates them
	always @(posedge CLK) begin
		if (!rstN) begin
			resetQuiet: assert (!renamedValid && !renameStall) else
				failCheck("output active during reset");
			for (int r = 0; r < numArchRegs; r++) begin
				modelMap[r] = physRegT'(r);
			end
			expectedPc = '0;
			allocCount = 0;
			renamedCount = 0;
			stallCycles = 0;
			sinceRelease = 0;
		end else begin
			sinceRelease++;
			// First fetch goes out from address 0
			if (sinceRelease == 1) begin
				pcAtStart: assert (instrAddr == '0) else
					failCheck($sformatf("first fetch address %h, expected 0", instrAddr));
			end
			// Fetch, queue and rename take three edges
			if (sinceRelease <= 3) begin
				startQuiet: assert (!renamedValid) else
					failCheck("renamed output before first fetch could arrive");
			end
			if (stallCycles > 0) begin
				stallHolds: assert (!renamedValid) else
					failCheck("instruction renamed while stalled");
			end
			if (renamedValid) begin
				checkRenamed();
			end
			if (renameStall) begin
				stallOnEmpty: assert (allocCount == numPhysRegs - numArchRegs) else
					failCheck($sformatf("stall after only %0d allocations", allocCount));
				stallCycles++;
			end else begin
				stallCycles = 0;
			end
			if (renamedCount >= renamedTarget || stallCycles >= stallTarget) begin
				runDone <= 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Clock, reset and run control
	// --------------------------------------------------
	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("timeout: no progress");
		$display("Done: errors found");
		$fatal(1);
	end

	initial begin
		rstN = 1'b0;
		void'($urandom(17));
		fillProgram();
		repeat (5) @(negedge CLK);
		rstN = 1'b1;
		wait (runDone);
		@(negedge CLK);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module frontEndBench \
	-f verilog.f \
	-o frontEndSim \
	&& ./obj_dir/frontEndSim \
	|| exit 1

//--- source/decodeQueue.sv
`timescale 1ns/1ns
`default_nettype none

module decodeQueue import renamePkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic push,
	input wire fetchedT pushData,
	input wire logic pop,
	input wire logic flush,
	output fetchedT head,
	output logic headValid,
	output logic full
);

	typedef logic [$clog2(queueDepth)-1:0] queuePtrT;
	typedef logic [$clog2(queueDepth):0] queueCountT;

	fetchedT entries [queueDepth];
	queuePtrT rdPtr;
	queuePtrT wrPtr;
	queueCountT count;

	assign head = entries[rdPtr];
	assign headValid = (count != '0);
	assign full = (count == queueCountT'(queueDepth));

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else if (flush) begin
			// Everything after a jump is dropped
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge CLK) begin
		if (push) begin
			entries[wrPtr] <= pushData;
		end
	end

	// Fetch respects full, decode respects empty
	noPushFull: assert property (@(posedge CLK) disable iff (!rstN)
		full |-> !push);
	noPopEmpty: assert property (@(posedge CLK) disable iff (!rstN)
		!headValid |-> !pop);

endmodule

`default_nettype wire

//--- source/fetchControl.sv
`timescale 1ns/1ns
`default_nettype none

module fetchControl import mipsIsaPkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic queueFull,
	input wire logic redirect,
	input wire wordT redirectTarget,
	output logic fetchPush,
	output logic queueFlush,
	output wordT pc
);

	typedef enum logic [1:0] {
		stReset,
		stFetch,
		stRedirect
	} fetchStateT;

	fetchStateT state;
	fetchStateT nextState;

	// --------------------------------------------------
	// State machine
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stReset: nextState = stFetch;
			stFetch: begin
				if (redirect) begin
					nextState = stRedirect;
				end
			end
			// One dead cycle while the new target settles
			stRedirect: nextState = stFetch;
			default: nextState = stReset;
		endcase
	end

	// No push on the flush edge, the entry would be lost anyway
	assign fetchPush = (state == stFetch) && !queueFull && !redirect;
	assign queueFlush = redirect;

	programCounter programCounter_i (
		.CLK(CLK),
		.rstN(rstN),
		.advance(fetchPush),
		.load(redirect),
		.target(redirectTarget),
		.pc(pc)
	);

	// A flush is never mixed with a push, nor followed by one
	flushNoPush: assert property (@(posedge CLK) disable iff (!rstN)
		queueFlush |-> !fetchPush ##1 !fetchPush);

	// Jumps only reach the head while fetching normally
	redirectInFetch: assert property (@(posedge CLK) disable iff (!rstN)
		redirect |-> state == stFetch);

endmodule

`default_nettype wire

//--- source/instrDecode.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecode import mipsIsaPkg::*, renamePkg::*; (
	input wire fetchedT head,
	input wire logic headValid,
	input wire logic renameStall,
	output logic pop,
	output decodedT decoded,
	output logic decodedValid,
	output logic redirect,
	output wordT redirectTarget
);

	logic hasDest;
	archRegT dest;
	logic isJump;
	wordT pcPlus4;

	// --------------------------------------------------
	// Register fields
	// --------------------------------------------------
	always_comb begin
		hasDest = 1'b1;
		dest = head.instr.i.rt;
		case (head.instr.r.opcode)
			opRType: dest = head.instr.r.rd;
			opJal: dest = linkReg;
			opJ, opBeq, opBne, opSw: begin
				hasDest = 1'b0;
				dest = '0;
			end
			// addi, lw and unknown I-types write rt
			default: dest = head.instr.i.rt;
		endcase
	end

	always_comb begin
		decoded.pc = head.pc;
		decoded.instr = head.instr;
		decoded.srcA = head.instr.r.rs;
		decoded.srcB = head.instr.r.rt;
		decoded.dest = dest;
		// Writes to r0 are discarded, so they need no register
		decoded.regWrite = hasDest && (dest != '0);
	end

	assign decodedValid = headValid;
	assign pop = headValid && !renameStall;

	// --------------------------------------------------
	// Jumps
	// --------------------------------------------------
	assign isJump = (head.instr.j.opcode == opJ) || (head.instr.j.opcode == opJal);
	assign pcPlus4 = head.pc + 32'd4;

	// Only once the jump itself leaves the queue
	assign redirect = pop && isJump;
	assign redirectTarget = {pcPlus4[31:28], head.instr.j.index, 2'b00};

endmodule

`default_nettype wire

//--- source/mipsFrontEnd.sv
`timescale 1ns/1ns
`default_nettype none

module mipsFrontEnd import mipsIsaPkg::*, renamePkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	output wordT instrAddr,
	input wire wordT instrData,
	output renamedT renamed,
	output logic renamedValid,
	output logic renameStall
);

	logic fetchPush;
	logic queueFlush;
	logic queueFull;
	logic headValid;
	logic pop;
	logic decodedValid;
	logic redirect;
	wordT redirectTarget;
	fetchedT head;
	decodedT decoded;

	// --------------------------------------------------
	// Fetch
	// --------------------------------------------------
	fetchControl fetchControl_i (
		.CLK(CLK),
		.rstN(rstN),
		.queueFull(queueFull),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.fetchPush(fetchPush),
		.queueFlush(queueFlush),
		.pc(instrAddr)
	);

	// Fetched word is tagged with its own address
	decodeQueue decodeQueue_i (
		.CLK(CLK),
		.rstN(rstN),
		.push(fetchPush),
		.pushData({instrAddr, instrData}),
		.pop(pop),
		.flush(queueFlush),
		.head(head),
		.headValid(headValid),
		.full(queueFull)
	);

	// --------------------------------------------------
	// Decode and rename
	// --------------------------------------------------
	instrDecode instrDecode_i (
		.head(head),
		.headValid(headValid),
		.renameStall(renameStall),
		.pop(pop),
		.decoded(decoded),
		.decodedValid(decodedValid),
		.redirect(redirect),
		.redirectTarget(redirectTarget)
	);

	renameMap renameMap_i (
		.CLK(CLK),
		.rstN(rstN),
		.decoded(decoded),
		.decodedValid(decodedValid),
		.renameStall(renameStall),
		.renamed(renamed),
		.renamedValid(renamedValid)
	);

endmodule

`default_nettype wire

//--- source/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	// --------------------------------------------------
	// Basic word and register types
	// --------------------------------------------------
	typedef logic [31:0] wordT;
	typedef logic [4:0] archRegT;

	// Opcodes the front end tells apart
	// Other values decode as a writing I-type
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2B
	} opcodeT;

	// --------------------------------------------------
	// Instruction formats
	// --------------------------------------------------
	typedef struct packed {
		opcodeT opcode;
		archRegT rs;
		archRegT rt;
		archRegT rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		opcodeT opcode;
		archRegT rs;
		archRegT rt;
		logic [15:0] imm;
	} iTypeT;

	typedef struct packed {
		opcodeT opcode;
		logic [25:0] index;
	} jTypeT;

	// One fetched word, seen through whichever format applies
	typedef union packed {
		rTypeT r;
		iTypeT i;
		jTypeT j;
	} instrT;

	// JAL writes its return address here
	localparam archRegT linkReg = 5'd31;

endpackage

`default_nettype wire

//--- source/programCounter.sv
`timescale 1ns/1ns
`default_nettype none

module programCounter import mipsIsaPkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic advance,
	input wire logic load,
	input wire wordT target,
	output wordT pc
);

	// Jump target wins over sequential fetch
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (load) begin
			pc <= target;
		end else if (advance) begin
			pc <= pc + 32'd4;
		end
	end

	// Targets from decode keep the address word aligned
	pcAligned: assert property (@(posedge CLK) disable iff (!rstN)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- source/renameMap.sv
`timescale 1ns/1ns
`default_nettype none

module renameMap import renamePkg::*; (
	input wire logic CLK,
	input wire logic rstN,
	input wire decodedT decoded,
	input wire logic decodedValid,
	output logic renameStall,
	output renamedT renamed,
	output logic renamedValid
);

	typedef logic [$clog2(numPhysRegs - numArchRegs)-1:0] freeIdxT;
	typedef logic [$clog2(numPhysRegs - numArchRegs):0] freeCountT;

	physRegT mapTable [numArchRegs];
	physRegT freeList [numPhysRegs - numArchRegs];
	freeIdxT freeHead;
	freeCountT freeCount;

	logic freeEmpty;
	logic accept;
	logic allocate;
	physRegT nextFree;

	assign freeEmpty = (freeCount == '0);
	assign nextFree = freeList[freeHead];

	// Held until reset once the free list runs dry
	assign renameStall = decodedValid && decoded.regWrite && freeEmpty;
	assign accept = decodedValid && !renameStall;
	assign allocate = accept && decoded.regWrite;

	// --------------------------------------------------
	// Map table and free list
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			// Identity mapping, upper half free in order
			for (int r = 0; r < numArchRegs; r++) begin
				mapTable[r] <= physRegT'(r);
			end
			for (int f = 0; f < numPhysRegs - numArchRegs; f++) begin
				freeList[f] <= physRegT'(numArchRegs + f);
			end
			freeHead <= '0;
			freeCount <= freeCountT'(numPhysRegs - numArchRegs);
		end else if (allocate) begin
			mapTable[decoded.dest] <= nextFree;
			freeHead <= freeHead + 1'b1;
			freeCount <= freeCount - 1'b1;
		end
	end

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			renamedValid <= 1'b0;
		end else begin
			renamedValid <= accept;
		end
	end

	// Sources see the mapping from before this instruction's write
	always_ff @(posedge CLK) begin
		if (accept) begin
			renamed.pc <= decoded.pc;
			renamed.instr <= decoded.instr;
			renamed.physA <= mapTable[decoded.srcA];
			renamed.physB <= mapTable[decoded.srcB];
			renamed.physDest <= decoded.regWrite ? nextFree : '0;
			renamed.regWrite <= decoded.regWrite;
		end
	end

	// Nothing is ever returned, so the count only falls
	freeCountBound: assert property (@(posedge CLK) disable iff (!rstN)
		freeCount <= freeCountT'(numPhysRegs - numArchRegs)
		&& freeCount <= $past(freeCount));

endmodule

`default_nettype wire

//--- source/renamePkg.sv
`default_nettype none

package renamePkg;
	import mipsIsaPkg::*;

	// Register file and queue sizes
	localparam int numArchRegs = 32;
	localparam int numPhysRegs = 64;
	localparam int queueDepth = 4;

	typedef logic [5:0] physRegT;

	// --------------------------------------------------
	// Pipeline payloads
	// --------------------------------------------------
	// Fetch to decode queue
	typedef struct packed {
		wordT pc;
		instrT instr;
	} fetchedT;

	// Decode to rename
	typedef struct packed {
		wordT pc;
		instrT instr;
		archRegT srcA;
		archRegT srcB;
		archRegT dest;
		logic regWrite;
	} decodedT;

	// Rename output, destination 0 for non-writers
	typedef struct packed {
		wordT pc;
		instrT instr;
		physRegT physA;
		physRegT physB;
		physRegT physDest;
		logic regWrite;
	} renamedT;

endpackage

`default_nettype wire

//--- verilog.f
source/mipsIsaPkg.sv
source/renamePkg.sv
source/programCounter.sv
source/fetchControl.sv
source/decodeQueue.sv
source/instrDecode.sv
source/renameMap.sv
source/mipsFrontEnd.sv
bench/frontEndBench.sv
